// ==== common/vlane_consts.svh ====
// Lane sequencer constants
// Lane count, memory depth, element limits and width select codes

`ifndef VLANE_CONSTS_SVH
`define VLANE_CONSTS_SVH

// Geometry
`define VLANE_NUM           8
`define MEM_DEPTH           512     // Words per lane memory
`define MAX_VL_PER_LANE     256
`define INST_DELAY_MAX      `MAX_VL_PER_LANE

// Write width codes as issued with the instruction
`define WIDTH_BYTE          2'd1
`define WIDTH_HALF          2'd2
`define WIDTH_WORD          2'd3

// Element width codes that the write side also uses internally
`define SEW_8               2'd0
`define SEW_16              2'd1
`define SEW_32              2'd2

`endif

// ==== common/vlane_cfg_pkg.sv ====
// Lane sequencer configuration types
// Address, counter, vector length and byte-enable widths

`default_nettype none

`include "vlane_consts.svh"

package vlane_cfg_pkg;

    // One word location inside a lane memory
    typedef logic [$clog2(`MEM_DEPTH)-1:0] vrf_addr_t;

    typedef logic [$clog2(`MAX_VL_PER_LANE):0] cnt_t;                // Element index plus one bit
    typedef logic [$clog2(`VLANE_NUM*`MAX_VL_PER_LANE)-1:0] vl_t;    // Whole vector across all lanes

    typedef logic [3:0] bwen_t;                                       // Bytes of one lane word
    typedef bwen_t [`VLANE_NUM-1:0] lane_bwen_t;

    typedef logic [1:0] width_t;

endpackage

`default_nettype wire

// ==== common/vlane_inst_pkg.sv ====
// Lane sequencer instruction types
// Instruction kinds and sequencer states

`default_nettype none

package vlane_inst_pkg;

    typedef enum logic [1:0] {
        NORMAL = 2'd0,      // Read, delay, write
        STORE  = 2'd1,      // Read only
        LOAD   = 2'd2       // Write from load stream
    } inst_kind_e;

    typedef enum logic [1:0] {
        IDLE        = 2'd0,
        NORMAL_MODE = 2'd1,
        READ_MODE   = 2'd2,
        LOAD_MODE   = 2'd3
    } seq_state_e;

endpackage

`default_nettype wire

// ==== rtl/vlane_seq/vlane_seq_fsm.sv ====
// Lane sequencing stage
// Captures one instruction on start and steps it through its
// read, delay and write windows with a main counter. Drives the
// address counter and byte-enable controls of the next stage.

`default_nettype none

`include "vlane_consts.svh"

module vlane_seq_fsm import vlane_cfg_pkg::*, vlane_inst_pkg::*; (
    input  wire              clk_i,
    input  wire              rst_i,

    input  wire              start_i,
    input  wire inst_kind_e  inst_kind_i,
    input  wire vl_t         vl_i,
    input  wire cnt_t        inst_delay_i,
    input  wire width_t      wdata_width_i,
    input  wire width_t      vsew_i,
    input  wire              load_valid_i,
    input  wire              load_last_i,

    output logic             ready_o,
    output logic             store_data_valid_o,
    output logic             ready_for_load_o,
    output logic             waddr_load_o,
    output logic             raddr_load_o,
    output logic             waddr_en_o,
    output logic             raddr_en_o,
    output logic             write_active_o,
    output logic             load_mode_o,
    output width_t           write_width_o,
    output width_t           read_width_o
);

    localparam int LANE_SHIFT = $clog2(`VLANE_NUM);

    seq_state_e state_q, state_d;
    cnt_t       cnt_q;
    cnt_t       n_q, delay_q;           // Per-lane element count and write delay
    width_t     wwidth_q, rwidth_q;
    cnt_t       n_elems;
    cnt_t       last_cnt;
    logic       accept;
    logic       wr_window;

    //////////////////////////////////////////////////
    // Capture

    assign accept = (state_q == IDLE) && start_i;

    // Elements per lane rounded up
    assign n_elems = cnt_t'(vl_i >> LANE_SHIFT) + cnt_t'(vl_i[LANE_SHIFT-1:0] != '0);

    always_ff @(posedge clk_i) begin
        if (accept) begin
            n_q      <= n_elems;
            delay_q  <= (inst_delay_i > cnt_t'(`INST_DELAY_MAX)) ? cnt_t'(`INST_DELAY_MAX)
                                                                  : inst_delay_i;
            rwidth_q <= vsew_i;
            case (wdata_width_i)        // Into element width encoding
                `WIDTH_BYTE: wwidth_q <= `SEW_8;
                `WIDTH_HALF: wwidth_q <= `SEW_16;
                default:     wwidth_q <= `SEW_32;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // State machine and main counter

    assign last_cnt = delay_q + n_q - cnt_t'(1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    case (inst_kind_i)
                        NORMAL:  state_d = NORMAL_MODE;
                        STORE:   state_d = READ_MODE;
                        LOAD:    state_d = LOAD_MODE;
                        default: state_d = IDLE;
                    endcase
                end
            end
            NORMAL_MODE: if (cnt_q == last_cnt) state_d = IDLE;
            READ_MODE:   if (cnt_q == n_q - cnt_t'(1)) state_d = IDLE;
            LOAD_MODE:   if (load_valid_i && load_last_i) state_d = IDLE;   // Last beat ends it
            default:     state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_d == NORMAL_MODE || state_d == READ_MODE) begin
                cnt_q <= (state_q == IDLE) ? '0 : cnt_q + cnt_t'(1);
            end else begin
                cnt_q <= '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Controls

    // Write side opens once the pipeline delay has passed
    assign wr_window = (state_q == NORMAL_MODE) && (cnt_q >= delay_q);

    assign ready_o            = (state_q == IDLE);
    assign store_data_valid_o = (state_q == READ_MODE);
    assign ready_for_load_o   = (state_q == LOAD_MODE);
    assign load_mode_o        = (state_q == LOAD_MODE);
    assign waddr_load_o       = (state_q == IDLE);
    assign raddr_load_o       = (state_q == IDLE);

    assign raddr_en_o     = ((state_q == NORMAL_MODE) && (cnt_q < n_q)) || (state_q == READ_MODE);
    assign write_active_o = wr_window || (state_q == LOAD_MODE);
    assign waddr_en_o     = wr_window || ((state_q == LOAD_MODE) && load_valid_i);

    assign write_width_o = (state_q == LOAD_MODE) ? `SEW_32 : wwidth_q;    // Loads write words
    assign read_width_o  = rwidth_q;

endmodule

`default_nettype wire

// ==== rtl/vlane_seq/vlane_addr_counter.sv ====
// Lane memory word address counter
// Reloads a start address and steps once per word, so a byte
// width moves every 4th enable and a halfword every 2nd

`default_nettype none

`include "vlane_consts.svh"

module vlane_addr_counter import vlane_cfg_pkg::*; (
    input  wire             clk_i,
    input  wire             rst_i,
    input  wire vrf_addr_t  start_addr_i,
    input  wire             load_i,
    input  wire             en_i,
    input  wire width_t     width_i,
    output vrf_addr_t       addr_o
);

    logic [1:0] phase_q;        // Element slot within the word
    logic       step;

    always_comb begin
        case (width_i)
            `SEW_8:  step = (phase_q == 2'd3);
            `SEW_16: step = phase_q[0];
            default: step = 1'b1;               // One element per word location
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_o  <= '0;
            phase_q <= '0;
        end else if (load_i) begin
            addr_o  <= start_addr_i;
            phase_q <= '0;
        end else if (en_i) begin
            phase_q <= phase_q + 2'd1;
            if (step) begin
                addr_o <= addr_o + vrf_addr_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vlane_seq/vlane_bwen_gen.sv ====
// Byte-enable generator
// Rotating byte and halfword patterns copied to every lane,
// or the load stream enables while a load is running

`default_nettype none

`include "vlane_consts.svh"

module vlane_bwen_gen import vlane_cfg_pkg::*; (
    input  wire              clk_i,
    input  wire              rst_i,
    input  wire              active_i,
    input  wire              en_i,
    input  wire width_t      width_i,
    input  wire              load_mode_i,
    input  wire lane_bwen_t  load_bwen_i,
    output lane_bwen_t       vrf_bwen_o
);

    bwen_t byte_sel_q;          // One-hot byte slot
    logic  half_hi_q;           // Upper halfword selected
    bwen_t pattern;

    // Patterns restart at byte 0 whenever writing stops
    always_ff @(posedge clk_i) begin
        if (!rst_i || !active_i) begin
            byte_sel_q <= 4'b0001;
            half_hi_q  <= 1'b0;
        end else if (en_i) begin
            byte_sel_q <= {byte_sel_q[2:0], byte_sel_q[3]};
            half_hi_q  <= ~half_hi_q;
        end
    end

    always_comb begin
        case (width_i)
            `SEW_8:  pattern = byte_sel_q;
            `SEW_16: pattern = half_hi_q ? 4'b1100 : 4'b0011;
            default: pattern = 4'b1111;
        endcase
    end

    always_comb begin
        for (int lane = 0; lane < `VLANE_NUM; lane++) begin
            if (load_mode_i) begin
                vrf_bwen_o[lane] = en_i ? load_bwen_i[lane] : '0;   // Only on valid beats
            end else begin
                vrf_bwen_o[lane] = active_i ? pattern : '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vlane_seq/vlane_sequencer_top.sv ====
// Per-lane instruction sequencer
// Sequencing stage followed by the address/enable stage with one
// write counter, three read counters and the byte-enable generator

`default_nettype none

module vlane_sequencer_top import vlane_cfg_pkg::*, vlane_inst_pkg::*; (
    input  wire                   clk_i,
    input  wire                   rst_i,

    input  wire                   start_i,
    input  wire inst_kind_e       inst_kind_i,
    input  wire vl_t              vl_i,
    input  wire cnt_t             inst_delay_i,
    input  wire width_t           wdata_width_i,
    input  wire width_t           vsew_i,
    input  wire                   load_valid_i,
    input  wire                   load_last_i,
    input  wire vrf_addr_t        vrf_starting_waddr_i,
    input  wire vrf_addr_t [2:0]  vrf_starting_raddr_i,   // vs1, vs2, vs3
    input  wire lane_bwen_t       load_bwen_i,

    output logic                  ready_o,
    output logic                  store_data_valid_o,
    output logic                  ready_for_load_o,
    output vrf_addr_t             vrf_waddr_o,
    output vrf_addr_t [2:0]       vrf_raddr_o,
    output lane_bwen_t            vrf_bwen_o
);

    logic   waddr_load, raddr_load;
    logic   waddr_en, raddr_en;
    logic   write_active, load_mode;
    width_t write_width, read_width;

    //////////////////////////////////////////////////
    // Sequencing stage

    vlane_seq_fsm u_seq_fsm (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .inst_kind_i        (inst_kind_i),
        .vl_i               (vl_i),
        .inst_delay_i       (inst_delay_i),
        .wdata_width_i      (wdata_width_i),
        .vsew_i             (vsew_i),
        .load_valid_i       (load_valid_i),
        .load_last_i        (load_last_i),
        .ready_o            (ready_o),
        .store_data_valid_o (store_data_valid_o),
        .ready_for_load_o   (ready_for_load_o),
        .waddr_load_o       (waddr_load),
        .raddr_load_o       (raddr_load),
        .waddr_en_o         (waddr_en),
        .raddr_en_o         (raddr_en),
        .write_active_o     (write_active),
        .load_mode_o        (load_mode),
        .write_width_o      (write_width),
        .read_width_o       (read_width)
    );

    //////////////////////////////////////////////////
    // Address and byte-enable stage

    vlane_addr_counter u_waddr_cnt (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_addr_i (vrf_starting_waddr_i),
        .load_i       (waddr_load),
        .en_i         (waddr_en),
        .width_i      (write_width),
        .addr_o       (vrf_waddr_o)
    );

    for (genvar i = 0; i < 3; i++) begin : g_raddr
        vlane_addr_counter u_raddr_cnt (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .start_addr_i (vrf_starting_raddr_i[i]),
            .load_i       (raddr_load),
            .en_i         (raddr_en),
            .width_i      (read_width),
            .addr_o       (vrf_raddr_o[i])
        );
    end

    vlane_bwen_gen u_bwen_gen (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .active_i    (write_active),
        .en_i        (waddr_en),
        .width_i     (write_width),
        .load_mode_i (load_mode),
        .load_bwen_i (load_bwen_i),
        .vrf_bwen_o  (vrf_bwen_o)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset source
// Free-running clock and an active-low reset held for a few cycles

`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Released just after an edge
    initial begin
        rst_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/tb_vlane_sequencer.sv ====
// Testbench for the per-lane instruction sequencer
// Reads instruction vectors, drives the DUT cycle by cycle and checks
// the handshake, byte enables and final register file addresses

`default_nettype none

`include "vlane_consts.svh"

module tb_vlane_sequencer import vlane_cfg_pkg::*, vlane_inst_pkg::*; ();

    localparam int DRIVE_DLY = 2;           // After the rising edge

    logic            clk_i, rst_i;
    logic            start_i, load_valid_i, load_last_i;
    inst_kind_e      inst_kind_i;
    vl_t             vl_i;
    cnt_t            inst_delay_i;
    width_t          wdata_width_i, vsew_i;
    vrf_addr_t       vrf_starting_waddr_i;
    vrf_addr_t [2:0] vrf_starting_raddr_i;
    lane_bwen_t      load_bwen_i;
    logic            ready_o, store_data_valid_o, ready_for_load_o;
    vrf_addr_t       vrf_waddr_o;
    vrf_addr_t [2:0] vrf_raddr_o;
    lane_bwen_t      vrf_bwen_o;

    int          kind_q[$], vl_q[$], delay_q[$], width_q[$], sew_q[$];
    int          waddr_q[$], raddr_q[$], beats_q[$], nbwen_q[$];
    int          timeout_cycles, cycle_cnt;
    logic        limit_set;
    logic [15:0] lfsr_q;

    tb_clk_gen #(.PERIOD(40), .RST_CYCLES(2)) u_clk_gen (.clk_o(clk_i), .rst_o(rst_i));

    vlane_sequencer_top DUT (.*);

    //////////////////////////////////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error at time %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic [15:0] stepped;
        stepped = state >> 1;
        if (state[0]) begin
            stepped = stepped ^ 16'hB400;
        end
        return stepped;
    endfunction

    task automatic rand_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value[i] = lfsr_q[0];           // One step per bit
            lfsr_q   = lfsr_next(lfsr_q);
        end
    endtask

    // Byte one-hot rotates, halfwords alternate low then high
    function automatic logic [31:0] lane_pattern(input int wcode, input int k);
        logic [3:0]  pat;
        logic [31:0] all;
        case (wcode)
            1:       pat = 4'b0001 << (k % 4);
            2:       pat = (k % 2 == 0) ? 4'b0011 : 4'b1100;
            default: pat = 4'b1111;
        endcase
        all = '0;
        for (int lane = 0; lane < `VLANE_NUM; lane++) begin
            all[lane*4 +: 4] = pat;
        end
        return all;
    endfunction

    function automatic int write_per_word(input int wcode);
        return (wcode == 1) ? 4 : (wcode == 2) ? 2 : 1;
    endfunction

    function automatic int read_per_word(input int sew);
        return (sew == 0) ? 4 : (sew == 1) ? 2 : 1;
    endfunction

    task automatic read_vectors();
        int    fd, n;
        int    f[9];
        string line;
        fd = $fopen("dv/vlane_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file dv/vlane_vectors.txt");
            $display("Something failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") continue;
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            if (n != 9) continue;
            kind_q.push_back(f[0]);
            vl_q.push_back(f[1]);
            delay_q.push_back(f[2]);
            width_q.push_back(f[3]);
            sew_q.push_back(f[4]);
            waddr_q.push_back(f[5]);
            raddr_q.push_back(f[6]);
            beats_q.push_back(f[7]);
            nbwen_q.push_back(f[8]);
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////
    // One instruction from start cycle 0 up to the first idle cycle

    task automatic run_instruction(input int idx);
        inst_kind_e  kind;
        int          n, c, end_cycle, beats_done, nbwen_seen, wsteps, rsteps;
        int          raddr_start[3];
        logic        valid, prev_gap, finished;
        logic [31:0] bits, exp_bwen;
        kind = inst_kind_e'(2'(kind_q[idx]));
        n    = (vl_q[idx] + `VLANE_NUM - 1) / `VLANE_NUM;
        for (int i = 0; i < 3; i++) begin
            raddr_start[i] = (raddr_q[idx] + 64 * i) % `MEM_DEPTH;
        end
        @(posedge clk_i);
        #DRIVE_DLY;
        start_i              = 1'b1;
        inst_kind_i          = kind;
        vl_i                 = vl_t'(vl_q[idx]);
        inst_delay_i         = cnt_t'(delay_q[idx]);
        wdata_width_i        = width_t'(width_q[idx]);
        vsew_i               = width_t'(sew_q[idx]);
        vrf_starting_waddr_i = vrf_addr_t'(waddr_q[idx]);
        for (int i = 0; i < 3; i++) begin
            vrf_starting_raddr_i[i] = vrf_addr_t'(raddr_start[i]);
        end
        case (kind)
            NORMAL:  end_cycle = delay_q[idx] + n + 1;
            STORE:   end_cycle = n + 1;
            default: end_cycle = 1 << 30;   // Fixed by the last beat
        endcase
        c          = 0;
        beats_done = 0;
        nbwen_seen = 0;
        prev_gap   = 1'b0;
        finished   = 1'b0;
        while (!finished) begin
            c++;
            @(posedge clk_i);
            #DRIVE_DLY;
            start_i      = 1'b0;
            load_valid_i = 1'b0;
            load_last_i  = 1'b0;
            valid        = 1'b0;
            if (c == 2 && c < end_cycle) begin      // Sent while busy so it must be dropped
                start_i     = 1'b1;
                inst_kind_i = inst_kind_e'(2'((kind_q[idx] + 1) % 3));
                vl_i        = vl_t'(vl_q[idx] + 8);
            end
            if (kind == LOAD && c < end_cycle) begin
                rand_bits(1, bits);
                valid    = bits[0] | prev_gap;      // At most one gap in a row
                prev_gap = !valid;
                if (valid) begin
                    rand_bits(32, bits);
                    load_bwen_i  = bits | 32'd1;
                    load_valid_i = 1'b1;
                    load_last_i  = (beats_done == beats_q[idx] - 1);
                    if (load_last_i) begin
                        end_cycle = c + 1;
                    end
                end
            end
            @(negedge clk_i);
            exp_bwen = '0;
            if (kind == NORMAL && c > delay_q[idx] && c <= delay_q[idx] + n) begin
                exp_bwen = lane_pattern(width_q[idx], c - delay_q[idx] - 1);
            end else if (kind == LOAD && valid) begin
                exp_bwen = load_bwen_i;
            end
            check_value("ready_o", 32'(c >= end_cycle), 32'(ready_o));
            check_value("store_data_valid_o", 32'(kind == STORE && c <= n),
                        32'(store_data_valid_o));
            check_value("ready_for_load_o", 32'(kind == LOAD && c < end_cycle),
                        32'(ready_for_load_o));
            check_value("vrf_bwen_o", exp_bwen, vrf_bwen_o);
            if (vrf_bwen_o != '0) nbwen_seen++;
            if (c == end_cycle) begin
                finished = 1'b1;
                wsteps   = (kind == NORMAL) ? n / write_per_word(width_q[idx]) :
                           (kind == LOAD)   ? beats_q[idx] : 0;
                rsteps   = (kind == LOAD) ? 0 : n / read_per_word(sew_q[idx]);
                check_value("vrf_waddr_o", 32'((waddr_q[idx] + wsteps) % `MEM_DEPTH),
                            32'(vrf_waddr_o));
                for (int i = 0; i < 3; i++) begin
                    check_value($sformatf("vrf_raddr_o[%0d]", i),
                                32'((raddr_start[i] + rsteps) % `MEM_DEPTH),
                                32'(vrf_raddr_o[i]));
                end
                check_value("nonzero vrf_bwen_o cycles", 32'(nbwen_q[idx]), 32'(nbwen_seen));
            end else if (kind == LOAD) begin
                check_value("vrf_waddr_o", 32'((waddr_q[idx] + beats_done) % `MEM_DEPTH),
                            32'(vrf_waddr_o));
            end
            if (valid) beats_done++;
        end
    endtask

    //////////////////////////////////////////////////
    // Run control

    initial begin : timeout_watch
        cycle_cnt = 0;
        wait (limit_set === 1'b1);
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
        $display("Something failed");
        $fatal(1);
    end

    initial begin : main
        start_i              = 1'b0;
        inst_kind_i          = NORMAL;
        vl_i                 = '0;
        inst_delay_i         = '0;
        wdata_width_i        = '0;
        vsew_i               = '0;
        load_valid_i         = 1'b0;
        load_last_i          = 1'b0;
        vrf_starting_waddr_i = '0;
        vrf_starting_raddr_i = '0;
        load_bwen_i          = '0;
        limit_set            = 1'b0;
        lfsr_q               = 16'd45;
        read_vectors();
        if (kind_q.size() == 0) begin
            $display("The vector file holds no instructions");
            $display("Something failed");
            $fatal(1);
        end
        timeout_cycles = 20;                // Reset and slack
        foreach (kind_q[i]) begin
            timeout_cycles += delay_q[i] + vl_q[i] / 8 + 2 * beats_q[i] + 10;
        end
        limit_set = 1'b1;
        wait (rst_i === 1'b1);
        @(negedge clk_i);
        check_value("ready_o", 32'd1, 32'(ready_o));
        check_value("store_data_valid_o", 32'd0, 32'(store_data_valid_o));
        check_value("ready_for_load_o", 32'd0, 32'(ready_for_load_o));
        check_value("vrf_bwen_o", 32'd0, vrf_bwen_o);
        for (int i = 0; i < kind_q.size(); i++) begin
            run_instruction(i);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/vlane_vectors.txt ====
# kind(0 normal, 1 store, 2 load) vl delay width(1 byte, 2 half, 3 word) sew waddr raddr beats bwen
# Decimal; read starts are raddr, raddr+64, raddr+128; bwen is the count of nonzero byte-enable cycles
0 64 3 3 2 10 100 0 8
0 13 1 1 0 500 20 0 2
1 64 0 3 2 15 25 0 0
0 100 5 1 0 507 300 0 13
2 0 0 3 2 30 0 12 12
0 80 2 2 1 200 40 0 10
1 8 0 1 0 0 400 0 0
0 7 4 2 1 0 0 0 1
2 0 0 1 0 510 0 5 5
0 256 20 3 2 508 480 0 32
1 150 0 1 1 0 123 0 0
0 33 1 1 1 60 70 0 5
2 0 0 2 1 100 0 1 1
0 2047 2 3 0 1 2 0 256
1 41 0 0 0 0 511 0 0
0 24 10 0 3 5 6 0 3
2 0 0 3 2 0 0 40 40
0 16 256 3 2 77 88 0 2
1 16 0 2 2 300 300 0 0
0 9 7 2 0 111 222 0 2

// ==== build.f ====
+incdir+common
common/vlane_cfg_pkg.sv
common/vlane_inst_pkg.sv
rtl/vlane_seq/vlane_seq_fsm.sv
rtl/vlane_seq/vlane_addr_counter.sv
rtl/vlane_seq/vlane_bwen_gen.sv
rtl/vlane_seq/vlane_sequencer_top.sv
dv/tb_clk_gen.sv
dv/tb_vlane_sequencer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the lane sequencer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module tb_vlane_sequencer \
    -f build.f \
    -o sim_vlane

./obj_dir/sim_vlane
